//--- logic/mmu_pkg.sv
// MMU shared types and widths

package mmu_pkg;

    // ------------------------------------------------------------------------
    // Address geometry
    // ------------------------------------------------------------------------
    localparam int unsigned VADDR_WIDTH = 39;
    localparam int unsigned PADDR_WIDTH = 40;
    localparam int unsigned PAGE_OFFSET = 12;
    localparam int unsigned VPN_WIDTH   = VADDR_WIDTH - PAGE_OFFSET;
    localparam int unsigned PPN_WIDTH   = PADDR_WIDTH - PAGE_OFFSET;

    typedef logic [VPN_WIDTH-1:0]   vpn_t;
    typedef logic [PPN_WIDTH-1:0]   ppn_t;
    typedef logic [PADDR_WIDTH-1:0] paddr_t;
    typedef logic [63:0]            word_t;

    // RISC-V privilege encoding without the hypervisor level
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_lvl_t;

    typedef enum logic [1:0] {
        ACC_FETCH = 2'b00,
        ACC_LOAD  = 2'b01,
        ACC_STORE = 2'b10
    } access_t;

    // ------------------------------------------------------------------------
    // Page table entry in RISC-V bit positions
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [25:0] reserved;
        ppn_t        ppn;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // ------------------------------------------------------------------------
    // Lookup, walk and memory traffic
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic    valid;
        vpn_t    vpn;
        access_t access;
    } tlb_req_t;

    typedef struct packed {
        logic hit;
        logic miss;
        ppn_t ppn;
        logic xcpt;
    } tlb_resp_t;

    typedef struct packed {
        logic valid;
        vpn_t vpn;
    } walk_req_t;

    typedef struct packed {
        logic valid;
        logic fault;
        pte_t pte;
    } walk_fill_t;

    typedef struct packed {
        paddr_t addr;
    } mem_req_t;

endpackage

//--- logic/tlb.sv
// Fully associative TLB

`timescale 1ns/1ps

module tlb
    import mmu_pkg::*;
#(
    parameter int unsigned TlbEntries = 8
)(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  priv_lvl_t  priv_lvl_i,
    input  logic       vm_enable_i,

    // Lookup port
    input  tlb_req_t   req_i,
    output tlb_resp_t  resp_o,

    // Walker port
    output walk_req_t  walk_req_o,
    input  walk_fill_t fill_i
);

    localparam int unsigned IdxW = (TlbEntries > 1) ? $clog2(TlbEntries) : 1;

    // Entry storage
    logic [TlbEntries-1:0] entry_valid_q;
    vpn_t                  entry_vpn_q [TlbEntries];
    pte_t                  entry_pte_q [TlbEntries];
    logic [IdxW-1:0]       victim_q;

    // Faulting walk waiting to be reported
    logic                  fault_q;
    vpn_t                  fault_vpn_q;

    logic                  match;
    pte_t                  match_pte;
    logic                  acc_ok;
    logic                  mode_ok;
    logic                  perm_fault;
    logic                  fault_hit;
    logic                  install;
    logic                  fill_fault;

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------
    always_comb begin
        match     = 1'b0;
        match_pte = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (entry_valid_q[i] && (entry_vpn_q[i] == req_i.vpn)) begin
                match     = 1'b1;
                match_pte = entry_pte_q[i];
            end
        end
    end

    // Permission check on the matching entry
    always_comb begin
        case (req_i.access)
            ACC_FETCH: acc_ok = match_pte.x;
            ACC_LOAD:  acc_ok = match_pte.r;
            default:   acc_ok = match_pte.w;
        endcase

        case (priv_lvl_i)
            PRIV_U:  mode_ok = match_pte.u;
            PRIV_S:  mode_ok = !match_pte.u;
            default: mode_ok = 1'b1;
        endcase

        // M mode ignores both checks
        perm_fault = (priv_lvl_i != PRIV_M) && !(acc_ok && mode_ok);
    end

    assign fault_hit = fault_q && req_i.valid && (req_i.vpn == fault_vpn_q);

    always_comb begin
        resp_o.hit  = req_i.valid && (!vm_enable_i || match);
        resp_o.miss = req_i.valid && vm_enable_i && !match;
        resp_o.ppn  = vm_enable_i ? match_pte.ppn : ppn_t'(req_i.vpn);
        resp_o.xcpt = req_i.valid && vm_enable_i &&
                      ((match && perm_fault) || (!match && fault_hit));
    end

    // Miss stays raised until the fill lands or a fault is reported
    assign walk_req_o.valid = resp_o.miss && !fault_hit;
    assign walk_req_o.vpn   = req_i.vpn;

    // ------------------------------------------------------------------------
    // Fill and flush
    // ------------------------------------------------------------------------
    assign install    = fill_i.valid && !fill_i.fault && fill_i.pte.v;
    assign fill_fault = fill_i.valid && (fill_i.fault || !fill_i.pte.v);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            entry_valid_q <= '0;
            victim_q      <= '0;
            fault_q       <= 1'b0;
        end else begin
            if (flush_i) begin
                entry_valid_q <= '0;
            end else if (install) begin
                entry_valid_q[victim_q] <= 1'b1;
            end

            // Round-robin replacement
            if (install) begin
                if (victim_q == IdxW'(TlbEntries - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end

            // Held until the requester moves on
            if (fill_fault) begin
                fault_q <= 1'b1;
            end else if (!fault_hit) begin
                fault_q <= 1'b0;
            end
        end
    end

    // Requester holds its VPN while the walk is out
    always_ff @(posedge clk_i) begin
        if (install) begin
            entry_vpn_q[victim_q] <= req_i.vpn;
            entry_pte_q[victim_q] <= fill_i.pte;
        end
        if (fill_fault) begin
            fault_vpn_q <= req_i.vpn;
        end
    end

endmodule

//--- logic/page_walker.sv
// Single-level page table walker

`timescale 1ns/1ps

module page_walker
    import mmu_pkg::*;
#(
    parameter int unsigned MemWords = 2
)(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  paddr_t                pt_base_i,

    // TLB side
    input  walk_req_t             itlb_walk_i,
    input  walk_req_t             dtlb_walk_i,
    output walk_fill_t            itlb_fill_o,
    output walk_fill_t            dtlb_fill_o,

    // Memory request with valid/ready
    output logic                  mem_req_valid_o,
    output mem_req_t              mem_req_o,
    input  logic                  mem_req_ready_i,

    // Memory response without back-pressure
    input  logic                  mem_resp_valid_i,
    input  word_t [MemWords-1:0]  mem_resp_data_i
);

    localparam int unsigned SelW = (MemWords > 1) ? $clog2(MemWords) : 1;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_REQ,
        WALK_WAIT
    } walk_state_e;

    walk_state_e     state_q;
    logic            fill_valid_q;

    // Walk context
    logic            owner_dtlb_q;
    paddr_t          pte_addr_q;
    pte_t            fill_pte_q;

    logic            walk_start;
    vpn_t            sel_vpn;
    logic [SelW-1:0] word_sel;
    logic            resp_take;

    // ------------------------------------------------------------------------
    // Arbitration with dTLB priority
    // ------------------------------------------------------------------------
    assign walk_start = (state_q == WALK_IDLE) && (dtlb_walk_i.valid || itlb_walk_i.valid);
    assign sel_vpn    = dtlb_walk_i.valid ? dtlb_walk_i.vpn : itlb_walk_i.vpn;

    // Response accepted once and the fill goes out the next cycle
    assign resp_take  = (state_q == WALK_WAIT) && mem_resp_valid_i && !fill_valid_q;

    // Word position inside the response block
    assign word_sel = (MemWords == 1) ? '0 : pte_addr_q[3 +: SelW];

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= WALK_IDLE;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= 1'b0;
            case (state_q)
                WALK_IDLE: begin
                    if (walk_start) begin
                        state_q <= WALK_REQ;
                    end
                end
                WALK_REQ: begin
                    // Request held until accepted
                    if (mem_req_ready_i) begin
                        state_q <= WALK_WAIT;
                    end
                end
                WALK_WAIT: begin
                    // Leave after the fill pulse so the TLB has installed
                    if (fill_valid_q) begin
                        state_q <= WALK_IDLE;
                    end else if (mem_resp_valid_i) begin
                        fill_valid_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= WALK_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (walk_start) begin
            owner_dtlb_q <= dtlb_walk_i.valid;
            // PTE address is base plus VPN times eight
            pte_addr_q   <= pt_base_i + (paddr_t'(sel_vpn) << 3);
        end
        if (resp_take) begin
            fill_pte_q <= mem_resp_data_i[word_sel];
        end
    end

    assign mem_req_valid_o = (state_q == WALK_REQ);
    assign mem_req_o.addr  = pte_addr_q;

    // Fill steered back to whichever TLB started the walk
    always_comb begin
        itlb_fill_o.valid = fill_valid_q && !owner_dtlb_q;
        itlb_fill_o.fault = !fill_pte_q.v;
        itlb_fill_o.pte   = fill_pte_q;

        dtlb_fill_o.valid = fill_valid_q && owner_dtlb_q;
        dtlb_fill_o.fault = !fill_pte_q.v;
        dtlb_fill_o.pte   = fill_pte_q;
    end

endmodule

//--- logic/mmu_tile.sv
// MMU tile top level

`timescale 1ns/1ps

module mmu_tile
    import mmu_pkg::*;
#(
    parameter int unsigned TlbEntries = 8,
    parameter int unsigned MemWords   = 2
)(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  priv_lvl_t             priv_lvl_i,
    input  logic                  vm_enable_i,
    input  paddr_t                pt_base_i,

    // Instruction side lookup
    input  tlb_req_t              itlb_req_i,
    output tlb_resp_t             itlb_resp_o,

    // Data side lookup
    input  tlb_req_t              dtlb_req_i,
    output tlb_resp_t             dtlb_resp_o,

    // Page table memory
    output logic                  mem_req_valid_o,
    output mem_req_t              mem_req_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_resp_valid_i,
    input  word_t [MemWords-1:0]  mem_resp_data_i
);

    // TLB and walker links
    walk_req_t  itlb_walk;
    walk_req_t  dtlb_walk;
    walk_fill_t itlb_fill;
    walk_fill_t dtlb_fill;

    // ------------------------------------------------------------------------
    // Translation buffers
    // ------------------------------------------------------------------------
    tlb #(
        .TlbEntries (TlbEntries)
    ) itlb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .priv_lvl_i  (priv_lvl_i),
        .vm_enable_i (vm_enable_i),
        .req_i       (itlb_req_i),
        .resp_o      (itlb_resp_o),
        .walk_req_o  (itlb_walk),
        .fill_i      (itlb_fill)
    );

    tlb #(
        .TlbEntries (TlbEntries)
    ) dtlb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .priv_lvl_i  (priv_lvl_i),
        .vm_enable_i (vm_enable_i),
        .req_i       (dtlb_req_i),
        .resp_o      (dtlb_resp_o),
        .walk_req_o  (dtlb_walk),
        .fill_i      (dtlb_fill)
    );

    // ------------------------------------------------------------------------
    // Shared walker
    // ------------------------------------------------------------------------
    page_walker #(
        .MemWords (MemWords)
    ) walker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .pt_base_i        (pt_base_i),
        .itlb_walk_i      (itlb_walk),
        .dtlb_walk_i      (dtlb_walk),
        .itlb_fill_o      (itlb_fill),
        .dtlb_fill_o      (dtlb_fill),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i)
    );

endmodule

//--- verification/pte_table.svh
// Testbench page table contents

// PPN scrambled from the VPN and flags chosen by VPN bits 11:8
function automatic pte_t expected_pte(input vpn_t vpn);
    pte_t pte;
    pte     = '0;
    pte.ppn = {1'b1, vpn ^ 27'h2ab_cdef};
    pte.a   = 1'b1;
    pte.d   = 1'b1;
    pte.v   = 1'b1;
    pte.r   = 1'b1;
    pte.w   = 1'b1;
    pte.x   = 1'b1;
    case (vpn[11:8])
        // Read only code page
        4'h1: pte.w = 1'b0;
        // Data page, not executable
        4'h2: pte.x = 1'b0;
        // User page
        4'h3: pte.u = 1'b1;
        // Invalid entry
        4'h4: pte.v = 1'b0;
        default: ;
    endcase
    return pte;
endfunction

//--- verification/pte_memory_model.sv
// Page table memory model

`timescale 1ns/1ps

module pte_memory_model
    import mmu_pkg::*;
#(
    parameter int unsigned MemWords = 2,
    parameter paddr_t      PtBase   = '0
)(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  mem_req_t             req_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output word_t [MemWords-1:0] resp_data_o
);

    `include "pte_table.svh"

    integer      seed;
    logic        busy_q;
    int unsigned wait_q;
    paddr_t      addr_q;

    initial seed = 6;

    always @(posedge clk_i) begin
        vpn_t base_vpn;
        if (!rst_n_i) begin
            req_ready_o  <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_data_o  <= '0;
            busy_q       <= 1'b0;
            wait_q       <= 0;
        end else begin
            resp_valid_o <= 1'b0;
            // Random ready held low while a read is pending
            req_ready_o  <= !busy_q && !(req_valid_i && req_ready_o) &&
                            (($random(seed) & 3) != 0);
            if (req_valid_i && req_ready_o) begin
                busy_q <= 1'b1;
                addr_q <= req_i.addr;
                wait_q <= 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            end else if (busy_q) begin
                if (wait_q <= 1) begin
                    // Aligned block of MemWords entries
                    base_vpn = vpn_t'((addr_q - PtBase) >> 3) & ~vpn_t'(MemWords - 1);
                    for (int k = 0; k < MemWords; k++) begin
                        resp_data_o[k] <= word_t'(expected_pte(base_vpn + vpn_t'(k)));
                    end
                    resp_valid_o <= 1'b1;
                    busy_q       <= 1'b0;
                end else begin
                    wait_q <= wait_q - 1;
                end
            end
        end
    end

endmodule

//--- verification/mmu_tile_tb.sv
// MMU tile testbench

`timescale 1ns/1ps

module mmu_tile_tb
    import mmu_pkg::*;
;

    localparam int unsigned MemWords = 2;
    localparam paddr_t      PtBase   = 40'h00_8000_0000;
    localparam int          Timeout  = 300;

    `include "pte_table.svh"

    logic                 clk = 1'b0;
    logic                 rst_n, flush, vm_en, mem_req_valid, mem_req_ready, mem_resp_valid;
    priv_lvl_t            priv;
    paddr_t               pt_base;
    tlb_req_t             itlb_req, dtlb_req;
    tlb_resp_t            itlb_resp, dtlb_resp;
    mem_req_t             mem_req;
    word_t [MemWords-1:0] mem_resp_data;

    mem_req_t             mem_log[$];
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    always #10 clk = ~clk;

    mmu_tile #(.TlbEntries(8), .MemWords(MemWords)) mmu_tile_i (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush), .priv_lvl_i(priv),
        .vm_enable_i(vm_en), .pt_base_i(pt_base),
        .itlb_req_i(itlb_req), .itlb_resp_o(itlb_resp),
        .dtlb_req_i(dtlb_req), .dtlb_resp_o(dtlb_resp),
        .mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
        .mem_resp_valid_i(mem_resp_valid), .mem_resp_data_i(mem_resp_data)
    );

    pte_memory_model #(.MemWords(MemWords), .PtBase(PtBase)) pte_mem (
        .clk_i(clk), .rst_n_i(rst_n), .req_valid_i(mem_req_valid), .req_i(mem_req),
        .req_ready_o(mem_req_ready), .resp_valid_o(mem_resp_valid), .resp_data_o(mem_resp_data)
    );

    // Accepted memory requests in issue order
    always @(posedge clk) begin
        if (rst_n && mem_req_valid && mem_req_ready) mem_log.push_back(mem_req);
    end

    // ------------------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------------------
    function automatic tlb_resp_t expected_resp(priv_lvl_t p, logic vm, access_t acc, vpn_t vpn);
        tlb_resp_t r;
        pte_t      pte;
        logic      allowed;
        pte = expected_pte(vpn);
        r   = '0;
        if (!vm) begin
            r.hit = 1'b1;
            r.ppn = ppn_t'(vpn);
        end else if (!pte.v) begin
            r.miss = 1'b1;
            r.xcpt = 1'b1;
        end else begin
            allowed = (acc == ACC_FETCH) ? pte.x : (acc == ACC_LOAD) ? pte.r : pte.w;
            if (p == PRIV_U) allowed = allowed && pte.u;
            if (p == PRIV_S) allowed = allowed && !pte.u;
            r.hit  = 1'b1;
            r.ppn  = pte.ppn;
            r.xcpt = (p != PRIV_M) && !allowed;
        end
        return r;
    endfunction

    task automatic check_resp(string name, tlb_resp_t got, tlb_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem_req(string name, mem_req_t got, mem_req_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_walk(int idx, vpn_t vpn);
        mem_req_t exp;
        exp.addr = PtBase + paddr_t'(vpn) * 8;
        if (mem_log.size() <= idx) begin
            $display("memory request %0d for vpn %h never appeared", idx, vpn);
            errors++;
        end else begin
            check_mem_req("mem_req_o", mem_log[idx], exp);
        end
    endtask

    task automatic expect_walk_count(int n);
        if (mem_log.size() != n) begin
            $display("saw %0d memory requests where %0d were due", mem_log.size(), n);
            errors++;
        end
    endtask

    task automatic expect_miss(logic saw);
        if (!saw) begin
            $display("first lookup hit where a miss was due");
            errors++;
        end
    endtask

    task automatic end_test(string name, int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic set_mode(priv_lvl_t p, logic vm);
        @(posedge clk);
        priv  <= p;
        vm_en <= vm;
    endtask

    // Holds each request until it hits or faults
    task automatic translate_pair(input logic en_i, input vpn_t vpn_i, input access_t acc_i,
                                  input logic en_d, input vpn_t vpn_d, input access_t acc_d,
                                  output tlb_resp_t got_i, output tlb_resp_t got_d,
                                  output logic miss_i, output logic miss_d);
        tlb_req_t ri, rd;
        logic     busy_i, busy_d, first;
        int       cycles;
        ri = '{valid: en_i, vpn: vpn_i, access: acc_i};
        rd = '{valid: en_d, vpn: vpn_d, access: acc_d};
        busy_i = en_i;
        busy_d = en_d;
        got_i  = '0;
        got_d  = '0;
        miss_i = 1'b0;
        miss_d = 1'b0;
        first  = 1'b1;
        cycles = 0;
        @(posedge clk);
        itlb_req <= ri;
        dtlb_req <= rd;
        while (busy_i || busy_d) begin
            @(negedge clk);
            if (busy_i) begin
                if (first) miss_i = itlb_resp.miss;
                if (itlb_resp.hit || itlb_resp.xcpt) begin
                    got_i  = itlb_resp;
                    busy_i = 1'b0;
                end
            end
            if (busy_d) begin
                if (first) miss_d = dtlb_resp.miss;
                if (dtlb_resp.hit || dtlb_resp.xcpt) begin
                    got_d  = dtlb_resp;
                    busy_d = 1'b0;
                end
            end
            first = 1'b0;
            @(posedge clk);
            if (!busy_i) itlb_req <= '0;
            if (!busy_d) dtlb_req <= '0;
            cycles++;
            if (cycles > Timeout) begin
                $display("lookup still waiting for a hit or fault after %0d cycles", cycles);
                $display("Test failed");
                $finish;
            end
        end
    endtask

    task automatic lookup(logic is_d, vpn_t vpn, access_t acc,
                          output tlb_resp_t got, output logic saw_miss);
        tlb_resp_t ri, rd;
        logic      mi, md;
        translate_pair(!is_d, vpn, acc, is_d, vpn, acc, ri, rd, mi, md);
        got      = is_d ? rd : ri;
        saw_miss = is_d ? md : mi;
    endtask

    task automatic perm_case(priv_lvl_t p, logic is_d, vpn_t vpn, access_t acc);
        tlb_resp_t got;
        logic      saw;
        set_mode(p, 1'b1);
        lookup(is_d, vpn, acc, got, saw);
        check_resp(is_d ? "dtlb_resp_o" : "itlb_resp_o", got, expected_resp(p, 1'b1, acc, vpn));
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        tlb_resp_t ri, rd, got;
        logic      mi, md, saw;
        int        e0;
        vpn_t      vpn;
        rst_n    = 1'b0;
        flush    = 1'b0;
        vm_en    = 1'b0;
        priv     = PRIV_S;
        pt_base  = PtBase;
        itlb_req = '0;
        dtlb_req = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;
        mem_log.delete();
        translate_pair(1'b1, 27'h12345, ACC_FETCH, 1'b1, 27'h00abc, ACC_STORE, ri, rd, mi, md);
        check_resp("itlb_resp_o", ri, expected_resp(PRIV_S, 1'b0, ACC_FETCH, 27'h12345));
        check_resp("dtlb_resp_o", rd, expected_resp(PRIV_S, 1'b0, ACC_STORE, 27'h00abc));
        expect_walk_count(0);
        end_test("translation off", e0);

        // Consecutive VPNs cover every word of the response block
        e0 = errors;
        set_mode(PRIV_S, 1'b1);
        for (int k = 0; k < 4; k++) begin
            vpn = 27'h10 + vpn_t'(k);
            mem_log.delete();
            lookup(k[0], vpn, k[0] ? ACC_LOAD : ACC_FETCH, got, saw);
            expect_miss(saw);
            expect_walk_count(1);
            check_walk(0, vpn);
            check_resp("tlb_resp_o", got,
                       expected_resp(PRIV_S, 1'b1, k[0] ? ACC_LOAD : ACC_FETCH, vpn));
        end
        end_test("miss and fill", e0);

        e0 = errors;
        perm_case(PRIV_S, 1'b1, 27'h100, ACC_STORE);
        perm_case(PRIV_S, 1'b0, 27'h200, ACC_FETCH);
        perm_case(PRIV_U, 1'b1, 27'h011, ACC_LOAD);
        perm_case(PRIV_S, 1'b1, 27'h300, ACC_LOAD);
        perm_case(PRIV_U, 1'b1, 27'h300, ACC_LOAD);
        perm_case(PRIV_M, 1'b1, 27'h100, ACC_STORE);
        perm_case(PRIV_M, 1'b0, 27'h200, ACC_FETCH);
        end_test("permissions", e0);

        // Invalid PTE is never cached
        e0 = errors;
        set_mode(PRIV_S, 1'b1);
        for (int k = 0; k < 2; k++) begin
            mem_log.delete();
            lookup(1'b1, 27'h400, ACC_LOAD, got, saw);
            expect_miss(saw);
            expect_walk_count(1);
            check_resp("dtlb_resp_o", got, expected_resp(PRIV_S, 1'b1, ACC_LOAD, 27'h400));
        end
        end_test("invalid pte", e0);

        e0 = errors;
        mem_log.delete();
        translate_pair(1'b1, 27'h020, ACC_FETCH, 1'b1, 27'h031, ACC_LOAD, ri, rd, mi, md);
        expect_miss(mi);
        expect_miss(md);
        expect_walk_count(2);
        check_walk(0, 27'h031);
        check_walk(1, 27'h020);
        check_resp("itlb_resp_o", ri, expected_resp(PRIV_S, 1'b1, ACC_FETCH, 27'h020));
        check_resp("dtlb_resp_o", rd, expected_resp(PRIV_S, 1'b1, ACC_LOAD, 27'h031));
        end_test("simultaneous misses", e0);

        e0 = errors;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        mem_log.delete();
        lookup(1'b1, 27'h011, ACC_LOAD, got, saw);
        expect_miss(saw);
        expect_walk_count(1);
        check_walk(0, 27'h011);
        check_resp("dtlb_resp_o", got, expected_resp(PRIV_S, 1'b1, ACC_LOAD, 27'h011));
        end_test("flush", e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mmu_tile.f
+incdir+verification
logic/mmu_pkg.sv
logic/tlb.sv
logic/page_walker.sv
logic/mmu_tile.sv
verification/pte_memory_model.sv
verification/mmu_tile_tb.sv

//--- Bender.yml
package:
  name: mmu_tile

sources:
  - logic/mmu_pkg.sv
  - logic/tlb.sv
  - logic/page_walker.sv
  - logic/mmu_tile.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pte_memory_model.sv
      - verification/mmu_tile_tb.sv
